/* build.f */
design/mopshub_pkg.sv
design/elink_deser.sv
design/downlink_router.sv
design/uplink_arbiter.sv
design/elink_ser.sv
design/mopshub_top.sv
sim/mopshub_props.sv
sim/tb_mopshub_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the MOPSHUB testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_mopshub_top -f build.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Raise the error limit so bound assertion failures do not stop the run
./obj_dir/sim_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
exit 0

/* sim/tb_mopshub_top.sv */
module tb_mopshub_top;
  timeunit 1ns;
  timeprecision 100ps;
  import mopshub_pkg::*;

  localparam int N_DOWN    = 60;
  localparam int N_UP      = 60;
  localparam int N_BURST   = 2 * N_BUSES;
  localparam int WD_CYCLES = (N_DOWN + N_UP + N_BURST) * 50 + 2000;

  logic                   clk_40 = 1'b0;
  logic                   rst;
  logic [1:0]             elink_rx;
  can_msg_t [N_BUSES-1:0] bus_rx_msg;
  logic [N_BUSES-1:0]     bus_rx_strobe;
  logic [1:0]             elink_tx;
  can_msg_t               bus_tx_msg;
  logic [N_BUSES-1:0]     bus_tx_strobe;
  logic [COUNT_W-1:0]     drop_count;
  logic [COUNT_W-1:0]     overflow_count;

  integer seed = 6929;
  int     cycle = 0;
  int     down_errs = 0;
  int     up_errs = 0;
  int     count_errs = 0;
  int     exp_drops = 0;
  int     exp_ovf = 0;
  int     total_errs;

  // Downlink reference, one entry per routed frame
  int                 exp_cycle [N_DOWN];
  int                 exp_bus [N_DOWN];
  can_msg_t           exp_msg [N_DOWN];
  int                 exp_len = 0;
  int                 exp_pos = 0;
  logic [N_BUSES-1:0] want_strobe;

  // Uplink reference, at most one message in flight per bus
  can_msg_t pend_msg [N_BUSES];
  int       sent_cnt [N_BUSES] = '{default: 0};
  int       done_cnt [N_BUSES] = '{default: 0};
  int       rr_order [N_BURST];
  int       rr_len = 0;
  int       rr_pos = 0;
  int       last_bus = N_BUSES - 1;

  int                 dec_cnt = -1;
  logic [FRAME_W-1:0] dec_bits;

  mopshub_top DUT (.*);

  always #20 clk_40 = ~clk_40;

  always @(posedge clk_40)
    cycle <= cycle + 1;

  task automatic rand_msg(output can_msg_t m);
    m.cob_id  = COB_ID_W'($random(seed));
    m.payload = {$random(seed), $random(seed)};
  endtask

  function automatic bit traffic_drained();
    if (exp_pos != exp_len)
      return 1'b0;
    for (int b = 0; b < N_BUSES; b++)
    begin
      if (sent_cnt[b] != done_cnt[b])
        return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic wait_drained();
    while (!traffic_drained())
      @(posedge clk_40);
    // Room for the gap dibit
    repeat (4) @(posedge clk_40);
  endtask

  task automatic send_down_frame(input elink_frame_t f);
    logic [FRAME_W-1:0] bits;
    int                 r;
    bits = f;
    r = $random(seed);
    repeat (1 + int'(r[2:0]))
    begin
      @(posedge clk_40);
      elink_rx <= ELINK_IDLE;
    end
    @(posedge clk_40);
    elink_rx <= ELINK_SOF;
    repeat (DIBITS)
    begin
      @(posedge clk_40);
      elink_rx <= bits[FRAME_W-1 -: 2];
      bits = bits << 2;
    end
    // Cycle still holds the count before this edge, strobe follows three edges later
    if (f.bus_id < BUS_ID_W'(N_BUSES))
    begin
      exp_cycle[exp_len] = cycle + 4;
      exp_bus[exp_len]   = int'(f.bus_id);
      exp_msg[exp_len]   = f.msg;
      exp_len++;
    end
    else
      exp_drops++;
  endtask

  task automatic run_downlink();
    elink_frame_t f;
    int           r;
    for (int n = 0; n < N_DOWN; n++)
    begin
      r = $random(seed);
      rand_msg(f.msg);
      // About one frame in four is outside the group
      if (r[1:0] == 2'b00)
        f.bus_id = BUS_ID_W'(N_BUSES + int'(r[9:2]) % 24);
      else
        f.bus_id = BUS_ID_W'(r[4:2]);
      // Runs of marker dibits inside the data
      if (r[11:10] == 2'b11)
        f.msg.payload[63:24] = '1;
      send_down_frame(f);
    end
    @(posedge clk_40);
    elink_rx <= ELINK_IDLE;
  endtask

  always @(negedge clk_40)
  begin
    want_strobe = '0;
    if (exp_pos < exp_len && exp_cycle[exp_pos] == cycle)
      want_strobe = N_BUSES'(1) << exp_bus[exp_pos];
    assert (bus_tx_strobe == want_strobe)
    else
    begin
      down_errs++;
      $display("ERR %0t bus_tx_strobe expected %h actual %h", $time, want_strobe, bus_tx_strobe);
    end
    if (want_strobe != '0)
    begin
      assert (bus_tx_msg == exp_msg[exp_pos])
      else
      begin
        down_errs++;
        $display("ERR %0t bus_tx_msg expected %h actual %h", $time, exp_msg[exp_pos],
                 bus_tx_msg);
      end
      exp_pos++;
    end
  end

  task automatic check_up_frame(input elink_frame_t f);
    int b;
    b = int'(f.bus_id);
    if (b >= N_BUSES || sent_cnt[b] == done_cnt[b])
    begin
      up_errs++;
      $display("Uplink frame for bus %0d arrived with no message pending", b);
    end
    else
    begin
      assert (f.msg == pend_msg[b])
      else
      begin
        up_errs++;
        $display("ERR %0t elink_tx msg expected %h actual %h", $time, pend_msg[b], f.msg);
      end
      done_cnt[b]++;
      last_bus = b;
    end
    if (rr_pos < rr_len)
    begin
      assert (b == rr_order[rr_pos])
      else
      begin
        up_errs++;
        $display("ERR %0t elink_tx bus_id expected %0d actual %0d", $time, rr_order[rr_pos], b);
      end
      rr_pos++;
    end
  endtask

  // E-link decoder, marker then forty dibits
  always @(negedge clk_40)
  begin
    if (dec_cnt < 0)
    begin
      if (rst && elink_tx == ELINK_SOF)
        dec_cnt = 0;
    end
    else
    begin
      dec_bits = {dec_bits[FRAME_W-3:0], elink_tx};
      dec_cnt++;
      if (dec_cnt == DIBITS)
      begin
        check_up_frame(elink_frame_t'(dec_bits));
        dec_cnt = -1;
      end
    end
  end

  task automatic strobe_buses(input logic [N_BUSES-1:0] mask, input bit accept);
    can_msg_t m;
    @(posedge clk_40);
    for (int b = 0; b < N_BUSES; b++)
    begin
      if (mask[b])
      begin
        rand_msg(m);
        bus_rx_msg[b] <= m;
        if (accept)
        begin
          pend_msg[b] = m;
          sent_cnt[b]++;
        end
        else
          exp_ovf++;
      end
    end
    bus_rx_strobe <= mask;
    @(posedge clk_40);
    bus_rx_strobe <= '0;
  endtask

  task automatic expect_rr_order();
    for (int i = 1; i <= N_BUSES; i++)
    begin
      rr_order[rr_len] = (last_bus + i) % N_BUSES;
      rr_len++;
    end
  endtask

  task automatic run_uplink();
    int                   sent;
    int                   r;
    logic [BUS_SEL_W-1:0] b;
    sent = 0;
    while (sent < N_UP)
    begin
      r = $random(seed);
      b = r[6:4];
      repeat (int'(r[3:0])) @(posedge clk_40);
      if (sent_cnt[b] == done_cnt[b])
      begin
        strobe_buses(N_BUSES'(1) << b, 1'b1);
        sent++;
      end
      else
        @(posedge clk_40);
    end
  endtask

  task automatic run_overflow_burst();
    logic [N_BUSES-1:0] late;
    late = '0;
    // Fifth to eighth in grant order stay full for over a hundred cycles
    for (int i = 5; i <= N_BUSES; i++)
      late[BUS_SEL_W'((last_bus + i) % N_BUSES)] = 1'b1;
    expect_rr_order();
    strobe_buses('1, 1'b1);
    repeat (5) @(posedge clk_40);
    strobe_buses(late, 1'b0);
  endtask

  initial
  begin
    rst           = 1'b0;
    elink_rx      = ELINK_IDLE;
    bus_rx_msg    = '0;
    bus_rx_strobe = '0;
    repeat (8) @(posedge clk_40);
    rst <= 1'b1;
    // First burst starts at bus 0
    expect_rr_order();
    strobe_buses('1, 1'b1);
    wait_drained();
    fork
      run_downlink();
      run_uplink();
    join
    wait_drained();
    run_overflow_burst();
    wait_drained();
    assert (drop_count == COUNT_W'((exp_drops > 255) ? 255 : exp_drops))
    else
    begin
      count_errs++;
      $display("ERR %0t drop_count expected %0d actual %0d", $time, exp_drops, drop_count);
    end
    assert (overflow_count == COUNT_W'(exp_ovf))
    else
    begin
      count_errs++;
      $display("ERR %0t overflow_count expected %0d actual %0d", $time, exp_ovf,
               overflow_count);
    end
    total_errs = down_errs + up_errs + count_errs + DUT.u_props.fail_count;
    $display("Errors: downlink %0d, uplink %0d, counters %0d, properties %0d",
             down_errs, up_errs, count_errs, DUT.u_props.fail_count);
    if (total_errs == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  initial
  begin
    repeat (WD_CYCLES) @(posedge clk_40);
    $display("Timeout after %0d cycles, traffic did not drain", WD_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* sim/mopshub_props.sv */
module mopshub_props (
  input logic                            clk_40,
  input logic                            rst,
  input logic [mopshub_pkg::N_BUSES-1:0] bus_tx_strobe,
  input logic [1:0]                      elink_tx,
  input logic                            ser_busy,
  input logic                            grant_valid
);
  timeunit 1ns;
  timeprecision 100ps;
  import mopshub_pkg::*;

  int   fail_count = 0;
  logic rst_seen = 1'b0;

  // Flops are in reset after the first clock with rst low
  always @(posedge clk_40)
  begin
    if (!rst)
      rst_seen <= 1'b1;
  end

  strobe_onehot: assert property (@(posedge clk_40) disable iff (!rst)
    $onehot0(bus_tx_strobe))
  else
  begin
    fail_count++;
    $error("bus_tx_strobe has more than one bit set");
  end

  // Line stays idle between frames
  tx_idle: assert property (@(posedge clk_40) disable iff (!rst)
    !ser_busy |-> elink_tx == ELINK_IDLE)
  else
  begin
    fail_count++;
    $error("elink_tx not idle while the serializer is idle");
  end

  grant_when_free: assert property (@(posedge clk_40) disable iff (!rst)
    !(grant_valid && ser_busy))
  else
  begin
    fail_count++;
    $error("grant_valid raised while the serializer is busy");
  end

  reset_quiet: assert property (@(posedge clk_40)
    (!rst && rst_seen) |-> (bus_tx_strobe == '0 && !grant_valid && !ser_busy))
  else
  begin
    fail_count++;
    $error("strobe or serializer active during reset");
  end

endmodule

bind mopshub_top mopshub_props u_props (
  .clk_40        (clk_40),
  .rst           (rst),
  .bus_tx_strobe (bus_tx_strobe),
  .elink_tx      (elink_tx),
  .ser_busy      (ser_busy),
  .grant_valid   (grant_valid)
);

/* design/mopshub_top.sv */
module mopshub_top (
  input  logic                                             clk_40,
  input  logic                                             rst,
  input  logic [1:0]                                       elink_rx,
  input  mopshub_pkg::can_msg_t [mopshub_pkg::N_BUSES-1:0] bus_rx_msg,
  input  logic [mopshub_pkg::N_BUSES-1:0]                  bus_rx_strobe,
  output logic [1:0]                                       elink_tx,
  output mopshub_pkg::can_msg_t                            bus_tx_msg,
  output logic [mopshub_pkg::N_BUSES-1:0]                  bus_tx_strobe,
  output logic [mopshub_pkg::COUNT_W-1:0]                  drop_count,
  output logic [mopshub_pkg::COUNT_W-1:0]                  overflow_count
);
  import mopshub_pkg::*;

  // Downlink between deserializer and router
  elink_frame_t frame_rx;
  logic         frame_rx_valid;

  // Uplink between arbiter and serializer
  elink_frame_t grant_frame;
  logic         grant_valid;
  logic         ser_busy;

  elink_deser u_elink_deser (
    .clk_40         (clk_40),
    .rst            (rst),
    .elink_rx       (elink_rx),
    .frame_rx       (frame_rx),
    .frame_rx_valid (frame_rx_valid)
  );

  downlink_router u_downlink_router (
    .clk_40         (clk_40),
    .rst            (rst),
    .frame_rx       (frame_rx),
    .frame_rx_valid (frame_rx_valid),
    .bus_tx_msg     (bus_tx_msg),
    .bus_tx_strobe  (bus_tx_strobe),
    .drop_count     (drop_count)
  );

  uplink_arbiter u_uplink_arbiter (
    .clk_40         (clk_40),
    .rst            (rst),
    .bus_rx_msg     (bus_rx_msg),
    .bus_rx_strobe  (bus_rx_strobe),
    .ser_busy       (ser_busy),
    .grant_frame    (grant_frame),
    .grant_valid    (grant_valid),
    .overflow_count (overflow_count)
  );

  elink_ser u_elink_ser (
    .clk_40      (clk_40),
    .rst         (rst),
    .grant_frame (grant_frame),
    .grant_valid (grant_valid),
    .elink_tx    (elink_tx),
    .ser_busy    (ser_busy)
  );

endmodule

/* design/elink_ser.sv */
module elink_ser (
  input  logic                      clk_40,
  input  logic                      rst,
  input  mopshub_pkg::elink_frame_t grant_frame,
  input  logic                      grant_valid,
  output logic [1:0]                elink_tx,
  output logic                      ser_busy
);
  import mopshub_pkg::*;

  ser_state_t             state;
  logic [DIBIT_CNT_W-1:0] dibit_cnt;
  logic [FRAME_W-1:0]     shift_reg;

  // SOF, forty data dibits, one gap dibit
  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      state     <= SS_IDLE;
      dibit_cnt <= '0;
    end
    else
    begin
      case (state)
        SS_IDLE:
        begin
          dibit_cnt <= '0;
          if (grant_valid)
            state <= SS_SOF;
        end
        SS_SOF:
          state <= SS_DATA;
        SS_DATA:
        begin
          dibit_cnt <= dibit_cnt + 1'b1;
          if (dibit_cnt == DIBIT_CNT_W'(DIBITS - 1))
            state <= SS_GAP;
        end
        SS_GAP:
          state <= SS_IDLE;
        default:
          state <= SS_IDLE;
      endcase
    end
  end

  // Latch on grant, then shift out MSB dibit first
  always_ff @(posedge clk_40)
  begin
    if (state == SS_IDLE && grant_valid)
      shift_reg <= grant_frame;
    else if (state == SS_DATA)
      shift_reg <= {shift_reg[FRAME_W-3:0], 2'b00};
  end

  always_comb
  begin
    case (state)
      SS_SOF:  elink_tx = ELINK_SOF;
      SS_DATA: elink_tx = shift_reg[FRAME_W-1:FRAME_W-2];
      default: elink_tx = ELINK_IDLE;
    endcase
  end

  // Covers SOF, data and gap, 42 cycles per frame
  assign ser_busy = (state != SS_IDLE);

endmodule

/* design/uplink_arbiter.sv */
module uplink_arbiter (
  input  logic                                          clk_40,
  input  logic                                          rst,
  input  mopshub_pkg::can_msg_t [mopshub_pkg::N_BUSES-1:0] bus_rx_msg,
  input  logic [mopshub_pkg::N_BUSES-1:0]               bus_rx_strobe,
  input  logic                                          ser_busy,
  output mopshub_pkg::elink_frame_t                     grant_frame,
  output logic                                          grant_valid,
  output logic [mopshub_pkg::COUNT_W-1:0]               overflow_count
);
  import mopshub_pkg::*;

  can_msg_t             slot_msg [N_BUSES];
  logic [N_BUSES-1:0]   slot_full;
  logic [N_BUSES-1:0]   slot_free;
  logic [N_BUSES-1:0]   ovf_hit;
  logic [BUS_SEL_W-1:0] last_grant;
  logic [BUS_SEL_W-1:0] pick_idx;
  logic                 pick_found;
  logic                 do_grant;
  logic [COUNT_W:0]     ovf_sum;

  // Round-robin search, starts one past the last granted bus
  always_comb
  begin
    logic [BUS_SEL_W-1:0] idx;
    pick_found = 1'b0;
    pick_idx   = '0;
    for (int i = 1; i <= N_BUSES; i++)
    begin
      idx = last_grant + BUS_SEL_W'(i);
      if (!pick_found && slot_full[idx])
      begin
        pick_found = 1'b1;
        pick_idx   = idx;
      end
    end
  end

  // The serializer raises busy one cycle after the grant pulse
  assign do_grant = pick_found && !ser_busy && !grant_valid;

  // A slot being granted this cycle can take a new message
  always_comb
  begin
    for (int b = 0; b < N_BUSES; b++)
    begin
      slot_free[b] = !slot_full[b] || (do_grant && pick_idx == BUS_SEL_W'(b));
      ovf_hit[b]   = bus_rx_strobe[b] && !slot_free[b];
    end
  end

  assign ovf_sum = {1'b0, overflow_count} + (COUNT_W + 1)'($countones(ovf_hit));

  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      slot_full      <= '0;
      grant_valid    <= 1'b0;
      last_grant     <= BUS_SEL_W'(N_BUSES - 1);
      overflow_count <= '0;
    end
    else
    begin
      grant_valid <= do_grant;
      if (do_grant)
      begin
        slot_full[pick_idx] <= 1'b0;
        last_grant          <= pick_idx;
      end
      // Set after the clear, so a refill wins
      for (int b = 0; b < N_BUSES; b++)
      begin
        if (bus_rx_strobe[b] && slot_free[b])
          slot_full[b] <= 1'b1;
      end
      if (ovf_sum[COUNT_W])
        overflow_count <= '1;
      else
        overflow_count <= ovf_sum[COUNT_W-1:0];
    end
  end

  // Slot storage and the granted frame
  always_ff @(posedge clk_40)
  begin
    for (int b = 0; b < N_BUSES; b++)
    begin
      if (bus_rx_strobe[b] && slot_free[b])
        slot_msg[b] <= bus_rx_msg[b];
    end
    if (do_grant)
    begin
      grant_frame.bus_id <= BUS_ID_W'(pick_idx);
      grant_frame.msg    <= slot_msg[pick_idx];
    end
  end

endmodule

/* design/downlink_router.sv */
module downlink_router (
  input  logic                                  clk_40,
  input  logic                                  rst,
  input  mopshub_pkg::elink_frame_t             frame_rx,
  input  logic                                  frame_rx_valid,
  output mopshub_pkg::can_msg_t                 bus_tx_msg,
  output logic [mopshub_pkg::N_BUSES-1:0]       bus_tx_strobe,
  output logic [mopshub_pkg::COUNT_W-1:0]       drop_count
);
  import mopshub_pkg::*;

  logic id_ok;
  logic [BUS_SEL_W-1:0] bus_sel;

  // Only the first N_BUSES numbers belong to this group
  assign id_ok   = (frame_rx.bus_id < BUS_ID_W'(N_BUSES));
  assign bus_sel = frame_rx.bus_id[BUS_SEL_W-1:0];

  // Strobe and drop counter
  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      bus_tx_strobe <= '0;
      drop_count    <= '0;
    end
    else
    begin
      bus_tx_strobe <= '0;
      if (frame_rx_valid)
      begin
        if (id_ok)
        begin
          bus_tx_strobe[bus_sel] <= 1'b1;
        end
        else if (drop_count != '1)
        begin
          // Saturates at all ones
          drop_count <= drop_count + 1'b1;
        end
      end
    end
  end

  // Message shared by all bus ports, valid with the strobe
  always_ff @(posedge clk_40)
  begin
    if (frame_rx_valid && id_ok)
      bus_tx_msg <= frame_rx.msg;
  end

endmodule

/* design/elink_deser.sv */
module elink_deser (
  input  logic                      clk_40,
  input  logic                      rst,
  input  logic [1:0]                elink_rx,
  output mopshub_pkg::elink_frame_t frame_rx,
  output logic                      frame_rx_valid
);
  import mopshub_pkg::*;

  deser_state_t           state;
  logic [1:0]             rx_q;
  logic [DIBIT_CNT_W-1:0] dibit_cnt;
  logic [FRAME_W-1:0]     shift_reg;

  // Input flop, the FSM runs one cycle behind the pins
  always_ff @(posedge clk_40)
  begin
    if (!rst)
      rx_q <= ELINK_IDLE;
    else
      rx_q <= elink_rx;
  end

  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      state          <= DS_IDLE;
      dibit_cnt      <= '0;
      frame_rx_valid <= 1'b0;
    end
    else
    begin
      frame_rx_valid <= 1'b0;
      case (state)
        DS_IDLE:
        begin
          dibit_cnt <= '0;
          if (rx_q == ELINK_SOF)
            state <= DS_DATA;
        end
        DS_DATA:
        begin
          // Marker value is plain data here
          dibit_cnt <= dibit_cnt + 1'b1;
          if (dibit_cnt == DIBIT_CNT_W'(DIBITS - 1))
          begin
            state          <= DS_IDLE;
            frame_rx_valid <= 1'b1;
          end
        end
        default:
          state <= DS_IDLE;
      endcase
    end
  end

  // Frame assembly, MSB dibit arrives first
  always_ff @(posedge clk_40)
  begin
    if (state == DS_DATA)
      shift_reg <= {shift_reg[FRAME_W-3:0], rx_q};
  end

  // Holds still until the next marker, so the router can sample it late
  assign frame_rx = elink_frame_t'(shift_reg);

endmodule

/* design/mopshub_pkg.sv */
package mopshub_pkg;

  // Bus group size and the derived select width
  localparam int N_BUSES   = 8;
  localparam int BUS_SEL_W = $clog2(N_BUSES);

  // Bus number field carried in every e-link frame
  // Values at or above N_BUSES are not routed
  localparam int BUS_ID_W = 5;

  // CAN message fields
  localparam int COB_ID_W  = 11;
  localparam int PAYLOAD_W = 64;

  // E-link frame geometry
  localparam int FRAME_W     = 80;
  localparam int DIBITS      = FRAME_W / 2;
  localparam int DIBIT_CNT_W = $clog2(DIBITS);

  // Width of the drop and overflow counters
  localparam int COUNT_W = 8;

  // Line codes on the 2-bit e-link
  localparam logic [1:0] ELINK_IDLE = 2'b00;
  localparam logic [1:0] ELINK_SOF  = 2'b11;

  // Parallel CAN message as seen by a bus port, 75 bits
  typedef struct packed {
    logic [COB_ID_W-1:0]  cob_id;
    logic [PAYLOAD_W-1:0] payload;
  } can_msg_t;

  // Frame on the e-link, bus number in the top bits
  // Sent most significant dibit first
  typedef struct packed {
    logic [BUS_ID_W-1:0] bus_id;
    can_msg_t            msg;
  } elink_frame_t;

  // Deserializer FSM
  typedef enum logic {
    DS_IDLE,
    DS_DATA
  } deser_state_t;

  // Serializer FSM
  // SS_GAP puts one idle dibit after every frame
  typedef enum logic [1:0] {
    SS_IDLE,
    SS_SOF,
    SS_DATA,
    SS_GAP
  } ser_state_t;

endpackage
